// ==== include/mul_params.svh ====
`ifndef MUL_PARAMS_SVH
`define MUL_PARAMS_SVH

// integer register width, RV64 only
`define MUL_XLEN 64

`define MUL_WORDW 32 // MULW operates on the low word

// two extra bits so that an unsigned source still reads as a positive
// signed value inside the booth recoder
`define MUL_OPW (`MUL_XLEN + 2)

// accumulator width
`define MUL_PRODW (2 * `MUL_XLEN + 2)

// one radix-4 group per cycle
`define MUL_MAX_STEPS (`MUL_OPW / 2)

`endif

// ==== source/mul_op_pkg.sv ====
`include "mul_params.svh"

package mul_op_pkg;

	// request side of the multiply unit

	// order follows funct3 of the OP major opcode
	// MULW shares funct3 000 with MUL in OP-32
	typedef enum logic [2:0] {
		MUL    = 3'd0, // low half
		MULH   = 3'd1, // high half, signed x signed
		MULHSU = 3'd2, // high half, signed x unsigned
		MULHU  = 3'd3, // high half, unsigned x unsigned
		MULW   = 3'd4  // low word, sign-extended
	} mul_op_e;

	typedef struct packed {
		mul_op_e               op;
		logic [`MUL_XLEN-1:0] rs1;
		logic [`MUL_XLEN-1:0] rs2;
	} mul_req_t;

endpackage

// ==== source/mul_data_pkg.sv ====
`include "mul_params.svh"

package mul_data_pkg;

	// datapath side of the multiply unit

	// both fields already carry the right extension for the opcode
	typedef struct packed {
		logic [`MUL_OPW-1:0] multiplicand; // from rs1
		logic [`MUL_OPW-1:0] multiplier;   // from rs2, booth recoded
	} mul_operands_t;

	// only the low 2*XLEN bits are ever read out
	typedef logic signed [`MUL_PRODW-1:0] mul_prod_t;

	typedef enum logic [1:0] {
		IDLE = 2'd0,
		RUN  = 2'd1, // one booth group per cycle
		DONE = 2'd2  // single cycle, product valid
	} booth_state_e;

endpackage

// ==== source/mul_operand_prep.sv ====
`include "mul_params.svh"

module mul_operand_prep
	import mul_op_pkg::*;
	import mul_data_pkg::*;
(
	input  mul_req_t      req,
	output mul_operands_t opnds
);

	logic                 signed_rs1;
	logic                 signed_rs2;
	logic [`MUL_XLEN-1:0] src1;
	logic [`MUL_XLEN-1:0] src2;
	logic                 ext1; // fill bit above rs1
	logic                 ext2; // fill bit above rs2

	always_comb begin
		signed_rs1 = 1'b1;
		signed_rs2 = 1'b1;
		src1 = req.rs1;
		src2 = req.rs2;
		case (req.op)
			MUL, MULH: begin
				signed_rs1 = 1'b1;
				signed_rs2 = 1'b1;
			end
			MULHSU: begin
				signed_rs1 = 1'b1;
				signed_rs2 = 1'b0;
			end
			MULHU: begin
				signed_rs1 = 1'b0;
				signed_rs2 = 1'b0;
			end
			MULW: begin
				// upper halves of the sources must not reach the low word
				src1 = {{(`MUL_XLEN - `MUL_WORDW){req.rs1[`MUL_WORDW-1]}},
					req.rs1[`MUL_WORDW-1:0]};
				src2 = {{(`MUL_XLEN - `MUL_WORDW){req.rs2[`MUL_WORDW-1]}},
					req.rs2[`MUL_WORDW-1:0]};
			end
			default: begin
				signed_rs1 = 1'b1;
				signed_rs2 = 1'b1;
			end
		endcase
	end

	assign ext1 = signed_rs1 & src1[`MUL_XLEN-1];
	assign ext2 = signed_rs2 & src2[`MUL_XLEN-1];

	always_comb begin
		opnds.multiplicand = {{(`MUL_OPW - `MUL_XLEN){ext1}}, src1};
		opnds.multiplier   = {{(`MUL_OPW - `MUL_XLEN){ext2}}, src2};
	end

endmodule

// ==== source/booth_radix4_mul.sv ====
`include "mul_params.svh"

module booth_radix4_mul
	import mul_data_pkg::*;
(
	input  logic          clk,
	input  logic          rst_n,
	input  logic          start,
	input  mul_operands_t opnds,
	output logic          busy,
	output logic          done,
	output mul_prod_t     prod
);

	// signed digit picked by one radix-4 group
	typedef enum logic [2:0] {
		PP_ZERO = 3'd0,
		PP_POS1 = 3'd1,
		PP_POS2 = 3'd2,
		PP_NEG1 = 3'd3,
		PP_NEG2 = 3'd4
	} booth_digit_e;

	booth_state_e       state_q;
	booth_state_e       state_d;
	booth_digit_e       digit;
	logic               accept;
	logic               mplr_flat;
	mul_prod_t          mcand_q; // multiplicand, moves up two bits per step
	mul_prod_t          acc_q;
	mul_prod_t          pp;
	logic [`MUL_OPW:0]  mplr_q;  // multiplier with guard bit at bit 0
	logic [`MUL_OPW:0]  mplr_next;

	assign accept = start && !busy;

	// arithmetic shift keeps the sign for the following groups
	assign mplr_next = {{2{mplr_q[`MUL_OPW]}}, mplr_q[`MUL_OPW:2]};

	// all zeros or all ones left means every further group is 000 or 111
	assign mplr_flat = (&mplr_next) || !(|mplr_next);

	always_comb begin
		case (mplr_q[2:0])
			3'b001, 3'b010: digit = PP_POS1;
			3'b011:         digit = PP_POS2;
			3'b100:         digit = PP_NEG2;
			3'b101, 3'b110: digit = PP_NEG1;
			default:        digit = PP_ZERO; // 000 and 111
		endcase
	end

	always_comb begin
		case (digit)
			PP_POS1: pp = mcand_q;
			PP_POS2: pp = mcand_q <<< 1;
			PP_NEG1: pp = -mcand_q;
			PP_NEG2: pp = -(mcand_q <<< 1);
			default: pp = '0;
		endcase
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (accept)
					state_d = RUN;
			end
			RUN: begin
				if (mplr_flat)
					state_d = DONE;
			end
			DONE: begin
				// back to back request skips idle
				if (accept)
					state_d = RUN;
				else
					state_d = IDLE;
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= IDLE;
			acc_q   <= '0;
		end else begin
			state_q <= state_d;
			if (accept)
				acc_q <= '0;
			else if (state_q == RUN)
				acc_q <= acc_q + pp;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			mcand_q <= {{(`MUL_PRODW - `MUL_OPW){opnds.multiplicand[`MUL_OPW-1]}},
				opnds.multiplicand};
			mplr_q  <= {opnds.multiplier, 1'b0};
		end else if (state_q == RUN) begin
			mcand_q <= mcand_q <<< 2;
			mplr_q  <= mplr_next;
		end
	end

	assign busy = (state_q == RUN);
	assign done = (state_q == DONE);
	assign prod = acc_q; // held until the next accepted start

endmodule

// ==== source/mul_result_sel.sv ====
`include "mul_params.svh"

module mul_result_sel
	import mul_op_pkg::*;
	import mul_data_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start,
	input  logic                 busy,
	input  mul_op_e              op,
	input  mul_prod_t            prod,
	output logic [`MUL_XLEN-1:0] result
);

	mul_op_e op_q;
	logic    accept;

	// same acceptance rule as the multiplier
	assign accept = start && !busy;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			op_q <= MUL;
		else if (accept)
			op_q <= op;
	end

	always_comb begin
		case (op_q)
			MUL: begin
				result = prod[`MUL_XLEN-1:0];
			end
			MULH, MULHSU, MULHU: begin
				result = prod[2*`MUL_XLEN-1:`MUL_XLEN];
			end
			MULW: begin
				result = {{(`MUL_XLEN - `MUL_WORDW){prod[`MUL_WORDW-1]}},
					prod[`MUL_WORDW-1:0]};
			end
			default: begin
				result = prod[`MUL_XLEN-1:0];
			end
		endcase
	end

endmodule

// ==== source/mul_unit.sv ====
`include "mul_params.svh"

module mul_unit
	import mul_op_pkg::*;
	import mul_data_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start,
	input  mul_req_t             req,
	output logic                 busy,
	output logic                 done,
	output logic [`MUL_XLEN-1:0] result
);

	mul_operands_t opnds;
	mul_prod_t     prod;

	// widening is combinational, latched by the multiplier on start
	mul_operand_prep u_operand_prep (
		.req   (req),
		.opnds (opnds)
	);

	booth_radix4_mul u_booth (
		.clk   (clk),
		.rst_n (rst_n),
		.start (start),
		.opnds (opnds),
		.busy  (busy),
		.done  (done),
		.prod  (prod)
	);

	mul_result_sel u_result_sel (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (start),
		.busy   (busy),
		.op     (req.op),
		.prod   (prod),
		.result (result)
	);

endmodule

// ==== sim/mul_unit_tb.sv ====
`include "mul_params.svh"

module mul_unit_tb
	import mul_op_pkg::*;
	import mul_data_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_DIRECTED = 21;
	localparam int NUM_RANDOM   = 40;
	localparam int NUM_ROWS     = NUM_DIRECTED + NUM_RANDOM;
	localparam int MAX_LATENCY  = `MUL_MAX_STEPS + 2; // start edge to done
	// two spare rows for reset and the idle window after the disturbed row
	localparam int WATCHDOG_NS  = (NUM_ROWS + 2) * (`MUL_MAX_STEPS + 4) * CLK_PERIOD * 2;

	localparam logic [`MUL_XLEN-1:0] ALL_ONES = '1;
	localparam logic [`MUL_XLEN-1:0] MIN_NEG  = 64'h8000_0000_0000_0000;
	localparam logic [`MUL_XLEN-1:0] PATTERN  = 64'h1234_5678_9abc_def0;

	typedef struct packed {
		mul_op_e              op;
		logic [`MUL_XLEN-1:0] rs1;
		logic [`MUL_XLEN-1:0] rs2;
		logic [`MUL_XLEN-1:0] expected;
		logic                 disturb; // second start while busy
	} row_t;

	logic                 clk;
	logic                 rst_n;
	logic                 start;
	mul_req_t             req;
	logic                 busy;
	logic                 done;
	logic [`MUL_XLEN-1:0] result;
	row_t                 rows [NUM_ROWS];
	int                   done_count = 0;

	mul_unit DUT (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (start),
		.req    (req),
		.busy   (busy),
		.done   (done),
		.result (result)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(negedge clk) begin
		if (done)
			done_count <= done_count + 1;
	end

	task automatic abort_run();
		$display("Regression failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_eq(input int idx, input string what,
		input logic [`MUL_XLEN-1:0] expected, input logic [`MUL_XLEN-1:0] actual);
		if (actual !== expected) begin
			$display("[FAIL] %0d ns row %0d %s expected %h got %h",
				$time, idx, what, expected, actual);
			abort_run();
		end
	endtask

	function automatic row_t make_row(input mul_op_e op, input logic [`MUL_XLEN-1:0] a,
		input logic [`MUL_XLEN-1:0] b, input logic [`MUL_XLEN-1:0] exp, input logic dis);
		row_t r;
		r.op       = op;
		r.rs1      = a;
		r.rs2      = b;
		r.expected = exp;
		r.disturb  = dis;
		return r;
	endfunction

	// exact 128 bit product with signedness per opcode
	function automatic logic [`MUL_XLEN-1:0] ref_result(input mul_op_e op,
		input logic [`MUL_XLEN-1:0] a, input logic [`MUL_XLEN-1:0] b);
		logic signed [2*`MUL_XLEN-1:0] sa;
		logic signed [2*`MUL_XLEN-1:0] sb;
		logic        [2*`MUL_XLEN-1:0] ua;
		logic        [2*`MUL_XLEN-1:0] ub;
		logic signed [2*`MUL_XLEN-1:0] sp;
		logic        [2*`MUL_XLEN-1:0] up;
		logic signed [31:0]            wa;
		logic signed [31:0]            wb;
		logic signed [63:0]            wp;
		sa = $signed(a);
		sb = $signed(b);
		ua = a;
		ub = b;
		wa = a[31:0];
		wb = b[31:0];
		wp = wa * wb;
		case (op)
			MUL: begin
				sp = sa * sb;
				return sp[`MUL_XLEN-1:0];
			end
			MULH: begin
				sp = sa * sb;
				return sp[2*`MUL_XLEN-1:`MUL_XLEN];
			end
			MULHSU: begin
				sp = sa * $signed(ub); // ub has a zero top bit
				return sp[2*`MUL_XLEN-1:`MUL_XLEN];
			end
			MULHU: begin
				up = ua * ub;
				return up[2*`MUL_XLEN-1:`MUL_XLEN];
			end
			default: return {{32{wp[31]}}, wp[31:0]}; // MULW
		endcase
	endfunction

	task automatic load_directed();
		rows[0]  = make_row(MUL, 64'd6, 64'd7, 64'd42, 1'b0);
		rows[1]  = make_row(MUL, 64'hffff_ffff_ffff_fffd, 64'd5, 64'hffff_ffff_ffff_fff1, 1'b0);
		rows[2]  = make_row(MUL, PATTERN, 64'd0, 64'd0, 1'b0);
		rows[3]  = make_row(MUL, PATTERN, 64'd1, PATTERN, 1'b0);
		rows[4]  = make_row(MUL, PATTERN, ALL_ONES, 64'hedcb_a987_6543_2110, 1'b0);
		rows[5]  = make_row(MUL, 64'd100, 64'd3, 64'd300, 1'b0);
		rows[6]  = make_row(MULW, 64'h7fff_ffff, 64'd2, 64'hffff_ffff_ffff_fffe, 1'b0);
		rows[7]  = make_row(MULW, 64'hdead_beef_8000_0000, 64'd1, 64'hffff_ffff_8000_0000, 1'b0);
		rows[8]  = make_row(MULW, 64'h1_0000_0003, 64'hffff_ffff_ffff_fffb,
			64'hffff_ffff_ffff_fff1, 1'b0);
		rows[9]  = make_row(MULW, 64'h1_0000, 64'h1_0000, 64'd0, 1'b0);
		rows[10] = make_row(MUL, MIN_NEG, MIN_NEG, 64'd0, 1'b0);
		rows[11] = make_row(MULH, MIN_NEG, MIN_NEG, 64'h4000_0000_0000_0000, 1'b0);
		rows[12] = make_row(MULH, ALL_ONES, ALL_ONES, 64'd0, 1'b0);
		rows[13] = make_row(MULHU, ALL_ONES, ALL_ONES, 64'hffff_ffff_ffff_fffe, 1'b0);
		rows[14] = make_row(MULHSU, ALL_ONES, ALL_ONES, ALL_ONES, 1'b0);
		rows[15] = make_row(MULHSU, MIN_NEG, MIN_NEG, 64'hc000_0000_0000_0000, 1'b0);
		rows[16] = make_row(MULH, ALL_ONES, 64'd2, ALL_ONES, 1'b0);
		rows[17] = make_row(MULHU, MIN_NEG, 64'd2, 64'd1, 1'b0);
		rows[18] = make_row(MULH, 64'h7fff_ffff_ffff_ffff, 64'h7fff_ffff_ffff_ffff,
			64'h3fff_ffff_ffff_ffff, 1'b0);
		rows[19] = make_row(MULHU, ALL_ONES, 64'd2, 64'd1, 1'b0);
		// alternating multiplier keeps the FSM in RUN for 32 cycles
		rows[20] = make_row(MUL, 64'd3, 64'h5555_5555_5555_5555, ALL_ONES, 1'b1);
	endtask

	task automatic add_random_rows();
		mul_op_e              op;
		logic [`MUL_XLEN-1:0] a;
		logic [`MUL_XLEN-1:0] b;
		for (int i = NUM_DIRECTED; i < NUM_ROWS; i++) begin
			op = mul_op_e'($urandom_range(4, 0));
			a  = {$urandom, $urandom};
			b  = {$urandom, $urandom};
			if ($urandom_range(3, 0) == 0)
				b = {{48{b[15]}}, b[15:0]}; // short multiplier for an early exit
			rows[i] = make_row(op, a, b, ref_result(op, a, b), 1'b0);
		end
	endtask

	task automatic check_reset_state();
		check_eq(-1, "busy in reset", 0, busy);
		check_eq(-1, "done in reset", 0, done);
		check_eq(-1, "result in reset", 0, result);
		check_eq(-1, "fsm state in reset", IDLE, DUT.u_booth.state_q);
	endtask

	task automatic wait_for_done(input int idx, inout int edges);
		do begin
			@(negedge clk);
			edges++;
			if (edges > 2 * MAX_LATENCY) begin
				$display("row %0d: done did not arrive within %0d cycles", idx, edges);
				abort_run();
			end
		end while (!done);
	endtask

	task automatic apply_row(input int idx);
		int edges;
		@(posedge clk);
		start   <= 1'b1;
		req.op  <= rows[idx].op;
		req.rs1 <= rows[idx].rs1;
		req.rs2 <= rows[idx].rs2;
		@(posedge clk);
		start <= 1'b0;
		edges = 1;
		if (rows[idx].disturb) begin
			@(negedge clk);
			check_eq(idx, "busy before second start", 1, busy);
			@(posedge clk);
			start   <= 1'b1; // should be dropped by the DUT
			req.op  <= MULHU;
			req.rs1 <= ~rows[idx].rs1;
			req.rs2 <= ALL_ONES;
			@(posedge clk);
			start <= 1'b0;
			edges = 3;
		end
		wait_for_done(idx, edges);
		if (edges > MAX_LATENCY) begin
			$display("row %0d: done took %0d cycles, more than %0d", idx, edges, MAX_LATENCY);
			abort_run();
		end
		check_eq(idx, "busy with done", 0, busy);
		check_eq(idx, "result", rows[idx].expected, result);
		if (rows[idx].disturb) begin
			repeat (`MUL_MAX_STEPS + 4) begin
				@(negedge clk);
				check_eq(idx, "extra done pulse", 0, done);
			end
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: done never arrived");
		abort_run();
	end

	initial begin
		rst_n = 1'b0;
		start = 1'b0;
		req   = '0;
		void'($urandom(32'ha4a254f6));
		load_directed();
		add_random_rows();
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			check_reset_state();
		end
		@(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_reset_state();
		for (int i = 0; i < NUM_ROWS; i++)
			apply_row(i);
		repeat (4) @(negedge clk);
		check_eq(-1, "done pulse count", NUM_ROWS, done_count);
		check_eq(-1, "fsm state at end", IDLE, DUT.u_booth.state_q);
		$display("Regression passed");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+include
source/mul_op_pkg.sv
source/mul_data_pkg.sv
source/mul_operand_prep.sv
source/booth_radix4_mul.sv
source/mul_result_sel.sv
source/mul_unit.sv
sim/mul_unit_tb.sv

// ==== Bender.yml ====
package:
  name: mul_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/mul_op_pkg.sv
      - source/mul_data_pkg.sv
      - source/mul_operand_prep.sv
      - source/booth_radix4_mul.sv
      - source/mul_result_sel.sv
      - source/mul_unit.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/mul_unit_tb.sv
